// File: filelist.f
+incdir+.
dcache_addr_pkg.sv
dcache_mem_pkg.sv
dcache_ram_sdp.sv
dcache_array.sv
dcache_ctrl.sv
dcache_top.sv
dcache_chk.sv
dcache_tb.sv

// File: Makefile
# Verilator flow for the cache testbench; every variable can be set on the command line
VERILATOR ?= verilator
TOP       ?= dcache_tb
SEED      ?= 32\'hd1331b37
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  := PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run fails unless the pass line shows up in the simulator output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: dcache_cases.txt
# op addr wdata expected, all hex; expected is checked for L and B, ignored for S
# op L is a load, S a store, B a load with a dropped store of wdata pulsed while busy
L 0010 00000000 5a5a0004
L 0014 00000000 5a5a0005
S 0018 11112222 00000000
L 0018 00000000 11112222
L 001c 00000000 5a5a0007
L 0110 00000000 5a5a0044
L 0018 00000000 11112222
L 0220 00000000 5a5a0088
L 0320 00000000 5a5a00c8
S 0324 aabbccdd 00000000
B 0324 55555555 aabbccdd
L 0324 00000000 aabbccdd
S 0430 deadbeef 00000000
L 0530 00000000 5a5a014c
L 0434 00000000 5a5a010d
L 0430 00000000 deadbeef
S fffc 01234567 00000000
L fff0 00000000 5a5a3ffc
L 00f0 00000000 5a5a003c
L fffc 00000000 01234567

// File: dcache_tb.sv
// run from the project root so dcache_cases.txt is found; memory delays come from SEED only
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_tb #(
    parameter logic [31:0] SEED = 32'hd133_1b37
);

    import dcache_addr_pkg::*;
    import dcache_mem_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int DONE_TIMEOUT = 200;
    localparam int SETTLE       = 4;
    localparam int DELAY_COUNT  = 256;
    localparam int OFF_W        = $clog2(`DCACHE_LINE_BYTES);
    localparam int WA_W         = `DCACHE_ADDR_W - $clog2(`DCACHE_WORD_W / 8);
    localparam int MEM_WORDS    = 1 << WA_W;
    localparam int NEWLINE      = 10;
    localparam int EOF_CHAR     = -1;

    logic   clk;
    logic   i_rst_n;
    logic   i_req;
    logic   i_we;
    addr_t  i_addr;
    word_t  i_wdata;
    logic   o_busy;
    logic   o_done;
    word_t  o_rdata;
    logic   o_mem_rd;
    logic   o_mem_wr;
    addr_t  o_mem_addr;
    line_t  o_mem_wr_line;
    logic   i_mem_rd_done;
    line_t  i_mem_rd_line;
    logic   i_mem_wr_done;

    // backing memory seen by the cache, and the word values the CPU should see
    word_t  mem_words [MEM_WORDS];
    word_t  ref_words [MEM_WORDS];

    // expected tag state of every line
    logic   mdl_valid [LINES];
    logic   mdl_dirty [LINES];
    tag_t   mdl_tag   [LINES];

    int          rd_count    = 0;
    int          wr_count    = 0;
    addr_t       last_rd_addr;
    addr_t       last_wr_addr;
    line_t       last_wr_line;
    int unsigned delay_q [$];
    int          error_count = 0;
    int          test_count  = 0;
    int          pass_count  = 0;

    dcache_top u_dcache_top (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_req         (i_req),
        .i_we          (i_we),
        .i_addr        (i_addr),
        .i_wdata       (i_wdata),
        .o_busy        (o_busy),
        .o_done        (o_done),
        .o_rdata       (o_rdata),
        .o_mem_rd      (o_mem_rd),
        .o_mem_wr      (o_mem_wr),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wr_line (o_mem_wr_line),
        .i_mem_rd_done (i_mem_rd_done),
        .i_mem_rd_line (i_mem_rd_line),
        .i_mem_wr_done (i_mem_wr_done)
    );

    // word w starts as w xor a constant, so every word in memory differs
    function automatic word_t init_word(logic [WA_W-1:0] wa);
        return {{(WORD_W - WA_W){1'b0}}, wa} ^ 32'h5a5a_0000;
    endfunction

    function automatic line_t ref_line(addr_t base);
        line_t           line;
        logic [WA_W-1:0] wa;

        wa = base[`DCACHE_ADDR_W-1 -: WA_W];
        for (int k = 0; k < LINE_WORDS; k++) begin
            line[k*WORD_W +: WORD_W] = ref_words[wa + k[WA_W-1:0]];
        end
        return line;
    endfunction

    task automatic report_mismatch(input string name, input line_t got, input line_t exp);
        $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
        error_count++;
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // answers each strobe with one done pulse after 1 to 8 cycles
    initial begin : memory_model
        int unsigned     delay;
        logic [WA_W-1:0] wa;
        logic            is_wr;

        i_mem_rd_done = 1'b0;
        i_mem_rd_line = '0;
        i_mem_wr_done = 1'b0;
        forever begin
            @(negedge clk);
            i_mem_rd_done = 1'b0;
            i_mem_wr_done = 1'b0;
            if (o_mem_wr || o_mem_rd) begin
                wa    = o_mem_addr[`DCACHE_ADDR_W-1 -: WA_W];
                is_wr = o_mem_wr;
                if (is_wr) begin
                    wr_count++;
                    last_wr_addr = o_mem_addr;
                    last_wr_line = o_mem_wr_line;
                    for (int k = 0; k < LINE_WORDS; k++) begin
                        mem_words[wa + k[WA_W-1:0]] = o_mem_wr_line[k*WORD_W +: WORD_W];
                    end
                end else begin
                    rd_count++;
                    last_rd_addr = o_mem_addr;
                    for (int k = 0; k < LINE_WORDS; k++) begin
                        i_mem_rd_line[k*WORD_W +: WORD_W] = mem_words[wa + k[WA_W-1:0]];
                    end
                end
                delay = 1;
                if (delay_q.size() > 0) begin
                    delay = delay_q.pop_front();
                end
                repeat (delay) @(negedge clk);
                if (is_wr) begin
                    i_mem_wr_done = 1'b1;
                end else begin
                    i_mem_rd_done = 1'b1;
                end
            end
        end
    end

    task automatic run_case(input logic [7:0] op, input addr_t addr, input word_t wdata,
                            input word_t exp_data, output logic aborted);
        index_t idx;
        tag_t   tag;
        logic   is_store;
        logic   hit;
        logic   expect_wb;
        addr_t  fill_base;
        addr_t  victim_base;
        line_t  victim_line;
        int     exp_rd;
        int     exp_wr;
        int     cycles;
        int     errors_before;

        aborted       = 1'b0;
        errors_before = error_count;
        is_store      = (op == "S");
        idx           = addr[OFF_W +: $bits(index_t)];
        tag           = addr[`DCACHE_ADDR_W-1 -: $bits(tag_t)];
        hit           = mdl_valid[idx] && (mdl_tag[idx] == tag);
        expect_wb     = !hit && mdl_valid[idx] && mdl_dirty[idx];
        exp_rd        = hit ? 0 : 1;
        exp_wr        = expect_wb ? 1 : 0;
        fill_base     = {tag, idx, {OFF_W{1'b0}}};
        victim_base   = {mdl_tag[idx], idx, {OFF_W{1'b0}}};
        victim_line   = ref_line(victim_base);
        rd_count      = 0;
        wr_count      = 0;
        if (op != "L" && op != "S" && op != "B") begin
            $display("ERROR: unknown operation '%c' in the case file", op);
            error_count++;
        end

        // accepted at the next rising edge, which is cycle 0
        i_req   = 1'b1;
        i_we    = is_store;
        i_addr  = addr;
        i_wdata = wdata;
        @(negedge clk);
        cycles = 1;
        i_req  = 1'b0;
        if (!o_busy) begin
            $display("ERROR: o_busy is low one cycle after an accepted request");
            error_count++;
        end
        // the second request arrives while busy and has to be dropped
        if (op == "B") begin
            i_req = 1'b1;
            i_we  = 1'b1;
        end
        while (!o_done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            i_req = 1'b0;
            cycles++;
        end
        i_req = 1'b0;

        if (!o_done) begin
            $display("ERROR: no o_done within %0d cycles of the request to %h",
                     DONE_TIMEOUT, addr);
            error_count++;
            aborted = 1'b1;
        end else begin
            if (!is_store && o_rdata !== exp_data) begin
                report_mismatch("o_rdata", line_t'(o_rdata), line_t'(exp_data));
            end
            if (hit && cycles != 2) begin
                report_mismatch("hit latency", line_t'(cycles), line_t'(2));
            end
            repeat (SETTLE) begin
                @(negedge clk);
                if (o_done) begin
                    $display("ERROR: extra o_done after the request to %h completed", addr);
                    error_count++;
                end
                if (o_busy) begin
                    $display("ERROR: o_busy is still high after the request to %h", addr);
                    error_count++;
                end
            end
            if (rd_count != exp_rd) begin
                report_mismatch("o_mem_rd count", line_t'(rd_count), line_t'(exp_rd));
            end
            if (!hit && last_rd_addr !== fill_base) begin
                report_mismatch("o_mem_addr", line_t'(last_rd_addr), line_t'(fill_base));
            end
            if (wr_count != exp_wr) begin
                report_mismatch("o_mem_wr count", line_t'(wr_count), line_t'(exp_wr));
            end
            if (expect_wb && last_wr_addr !== victim_base) begin
                report_mismatch("o_mem_addr", line_t'(last_wr_addr), line_t'(victim_base));
            end
            if (expect_wb && last_wr_line !== victim_line) begin
                report_mismatch("o_mem_wr_line", last_wr_line, victim_line);
            end
        end

        // a miss allocates the line, a store leaves it dirty
        if (!hit) begin
            mdl_valid[idx] = 1'b1;
            mdl_tag[idx]   = tag;
            mdl_dirty[idx] = is_store;
        end else if (is_store) begin
            mdl_dirty[idx] = 1'b1;
        end
        if (is_store) begin
            ref_words[addr[`DCACHE_ADDR_W-1 -: WA_W]] = wdata;
        end

        test_count++;
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %0d: %c %h ok", test_count, op, addr);
        end else begin
            $display("test %0d: %c %h FAILED", test_count, op, addr);
        end
    endtask

    initial begin : main
        int          fd;
        int          ch;
        int          code;
        logic [7:0]  op;
        addr_t       addr;
        word_t       wdata;
        word_t       exp_data;
        logic        aborted;

        i_rst_n       = 1'b0;
        i_req         = 1'b0;
        i_we          = 1'b0;
        i_addr        = '0;
        i_wdata       = '0;
        aborted       = 1'b0;
        mdl_valid     = '{default: 1'b0};
        mdl_dirty     = '{default: 1'b0};
        mdl_tag       = '{default: '0};

        void'($urandom(SEED));
        for (int n = 0; n < DELAY_COUNT; n++) begin
            delay_q.push_back($urandom_range(8, 1));
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem_words[w[WA_W-1:0]] = init_word(w[WA_W-1:0]);
            ref_words[w[WA_W-1:0]] = init_word(w[WA_W-1:0]);
        end

        repeat (RESET_CYCLES) @(negedge clk);
        i_rst_n = 1'b1;
        @(negedge clk);

        fd = $fopen("dcache_cases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open dcache_cases.txt");
            error_count++;
        end else begin
            while (!aborted) begin
                code = $fscanf(fd, " %c", op);
                if (code != 1) begin
                    break;
                end
                if (op == "#") begin
                    ch = $fgetc(fd);
                    while (ch != NEWLINE && ch != EOF_CHAR) begin
                        ch = $fgetc(fd);
                    end
                end else begin
                    code = $fscanf(fd, " %h %h %h", addr, wdata, exp_data);
                    if (code != 3) begin
                        $display("ERROR: malformed line in dcache_cases.txt after test %0d",
                                 test_count);
                        error_count++;
                        break;
                    end
                    run_case(op, addr, wdata, exp_data, aborted);
                end
            end
            $fclose(fd);
        end

        if (test_count == 0) begin
            $display("ERROR: no test cases were run");
            error_count++;
        end
        $display("tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 test_count, pass_count, test_count - pass_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: dcache_chk.sv
// watches only the top-level strobes; all properties except the reset one pause during reset
`timescale 1ns/100ps

module dcache_chk (
    input logic clk,
    input logic i_rst_n,
    input logic i_busy,
    input logic i_done,
    input logic i_mem_rd,
    input logic i_mem_wr
);

    // the memory side carries one transfer at a time
    mem_rd_wr_exclusive: assert property (
        @(posedge clk) disable iff (!i_rst_n) !(i_mem_rd && i_mem_wr)
    ) else $error("o_mem_rd and o_mem_wr are high in the same cycle");

    done_single_pulse: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_done |=> !i_done
    ) else $error("o_done is high for two cycles in a row");

    // busy only falls together with the done pulse
    done_while_busy: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_done |-> i_busy
    ) else $error("o_done is high while o_busy is low");

    quiet_in_reset: assert property (
        @(posedge clk) !i_rst_n |-> !(i_busy || i_done || i_mem_rd || i_mem_wr)
    ) else $error("a strobe is high while reset is asserted");

endmodule

bind dcache_top dcache_chk u_chk (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_busy   (o_busy),
    .i_done   (o_done),
    .i_mem_rd (o_mem_rd),
    .i_mem_wr (o_mem_wr)
);

// File: dcache_top.sv
// direct-mapped write-back cache; memory must answer each strobe with exactly one done pulse
`timescale 1ns/100ps

module dcache_top (
    input  logic                   clk,
    input  logic                   i_rst_n,

    // CPU side
    input  logic                   i_req,
    input  logic                   i_we,
    input  dcache_addr_pkg::addr_t i_addr,
    input  dcache_mem_pkg::word_t  i_wdata,
    output logic                   o_busy,
    output logic                   o_done,
    output dcache_mem_pkg::word_t  o_rdata,

    // memory side
    output logic                   o_mem_rd,
    output logic                   o_mem_wr,
    output dcache_addr_pkg::addr_t o_mem_addr,
    output dcache_mem_pkg::line_t  o_mem_wr_line,
    input  logic                   i_mem_rd_done,
    input  dcache_mem_pkg::line_t  i_mem_rd_line,
    input  logic                   i_mem_wr_done
);

    import dcache_addr_pkg::*;
    import dcache_mem_pkg::*;

    logic   arr_wr_en;
    index_t arr_wr_index;
    logic   arr_wr_valid;
    logic   arr_wr_dirty;
    tag_t   arr_wr_tag;
    line_t  arr_wr_line;
    logic   arr_rd_en;
    index_t arr_rd_index;
    logic   arr_rd_valid;
    logic   arr_rd_dirty;
    tag_t   arr_rd_tag;
    line_t  arr_rd_line;

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_req          (i_req),
        .i_we           (i_we),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .o_busy         (o_busy),
        .o_done         (o_done),
        .o_rdata        (o_rdata),
        .o_mem_rd       (o_mem_rd),
        .o_mem_wr       (o_mem_wr),
        .o_mem_addr     (o_mem_addr),
        .o_mem_wr_line  (o_mem_wr_line),
        .i_mem_rd_done  (i_mem_rd_done),
        .i_mem_rd_line  (i_mem_rd_line),
        .i_mem_wr_done  (i_mem_wr_done),
        .o_arr_wr_en    (arr_wr_en),
        .o_arr_wr_index (arr_wr_index),
        .o_arr_wr_valid (arr_wr_valid),
        .o_arr_wr_dirty (arr_wr_dirty),
        .o_arr_wr_tag   (arr_wr_tag),
        .o_arr_wr_line  (arr_wr_line),
        .o_arr_rd_en    (arr_rd_en),
        .o_arr_rd_index (arr_rd_index),
        .i_arr_rd_valid (arr_rd_valid),
        .i_arr_rd_dirty (arr_rd_dirty),
        .i_arr_rd_tag   (arr_rd_tag),
        .i_arr_rd_line  (arr_rd_line)
    );

    dcache_array u_array (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_wr_en    (arr_wr_en),
        .i_wr_index (arr_wr_index),
        .i_wr_valid (arr_wr_valid),
        .i_wr_dirty (arr_wr_dirty),
        .i_wr_tag   (arr_wr_tag),
        .i_wr_line  (arr_wr_line),
        .i_rd_en    (arr_rd_en),
        .i_rd_index (arr_rd_index),
        .o_rd_valid (arr_rd_valid),
        .o_rd_dirty (arr_rd_dirty),
        .o_rd_tag   (arr_rd_tag),
        .o_rd_line  (arr_rd_line)
    );

endmodule

// File: dcache_ctrl.sv
// blocking controller, one request at a time; requests while o_busy is high are dropped
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic                    clk,
    input  logic                    i_rst_n,

    // CPU side
    input  logic                    i_req,
    input  logic                    i_we,
    input  dcache_addr_pkg::addr_t  i_addr,
    input  dcache_mem_pkg::word_t   i_wdata,
    output logic                    o_busy,
    output logic                    o_done,
    output dcache_mem_pkg::word_t   o_rdata,

    // memory side
    output logic                    o_mem_rd,
    output logic                    o_mem_wr,
    output dcache_addr_pkg::addr_t  o_mem_addr,
    output dcache_mem_pkg::line_t   o_mem_wr_line,
    input  logic                    i_mem_rd_done,
    input  dcache_mem_pkg::line_t   i_mem_rd_line,
    input  logic                    i_mem_wr_done,

    // array write port
    output logic                    o_arr_wr_en,
    output dcache_addr_pkg::index_t o_arr_wr_index,
    output logic                    o_arr_wr_valid,
    output logic                    o_arr_wr_dirty,
    output dcache_addr_pkg::tag_t   o_arr_wr_tag,
    output dcache_mem_pkg::line_t   o_arr_wr_line,

    // array read port
    output logic                    o_arr_rd_en,
    output dcache_addr_pkg::index_t o_arr_rd_index,
    input  logic                    i_arr_rd_valid,
    input  logic                    i_arr_rd_dirty,
    input  dcache_addr_pkg::tag_t   i_arr_rd_tag,
    input  dcache_mem_pkg::line_t   i_arr_rd_line
);

    import dcache_addr_pkg::*;
    import dcache_mem_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    logic        accept;
    logic        hit;
    logic        hit_done;
    logic        fill_done;
    logic        mem_rd_q;
    logic        mem_wr_q;

    // latched request
    logic        req_we_q;
    tag_t        req_tag_q;
    index_t      req_index_q;
    woff_t       req_woff_q;
    word_t       req_wdata_q;

    // victim saved on a miss for the write-back
    tag_t        victim_tag_q;
    line_t       victim_line_q;

    line_t       base_line;
    line_t       merged_line;
    word_t       rdata_q;

    assign accept    = i_req && (state_q == IDLE);
    assign hit       = i_arr_rd_valid && (i_arr_rd_tag == req_tag_q);
    assign hit_done  = (state_q == LOOKUP) && hit;
    assign fill_done = (state_q == FILL) && i_mem_rd_done;

    // the array is read in the cycle the request is accepted
    assign o_arr_rd_en    = accept;
    assign o_arr_rd_index = get_index(i_addr);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_d = RESP;
                end else if (i_arr_rd_valid && i_arr_rd_dirty) begin
                    state_d = WBACK;
                end else begin
                    state_d = FILL;
                end
            end
            WBACK: begin
                if (i_mem_wr_done) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                if (i_mem_rd_done) begin
                    state_d = RESP;
                end
            end
            RESP:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // each memory strobe pulses once, on entry to its state
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q  <= IDLE;
            mem_rd_q <= 1'b0;
            mem_wr_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            mem_rd_q <= (state_q != FILL) && (state_d == FILL);
            mem_wr_q <= (state_q != WBACK) && (state_d == WBACK);
        end
    end

    // store data goes into the array copy on a hit and into the memory copy on a fill
    assign base_line = (state_q == FILL) ? i_mem_rd_line : i_arr_rd_line;

    always_comb begin
        merged_line = base_line;
        if (req_we_q) begin
            merged_line[req_woff_q*WORD_W +: WORD_W] = req_wdata_q;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_we_q    <= i_we;
            req_tag_q   <= get_tag(i_addr);
            req_index_q <= get_index(i_addr);
            req_woff_q  <= get_woff(i_addr);
            req_wdata_q <= i_wdata;
        end
        if ((state_q == LOOKUP) && !hit) begin
            victim_tag_q  <= i_arr_rd_tag;
            victim_line_q <= i_arr_rd_line;
        end
        // a store returns the word it wrote
        if (hit_done || fill_done) begin
            rdata_q <= merged_line[req_woff_q*WORD_W +: WORD_W];
        end
    end

    // a load hit leaves the array alone, everything else that completes writes the line back
    assign o_arr_wr_en    = (hit_done && req_we_q) || fill_done;
    assign o_arr_wr_index = req_index_q;
    assign o_arr_wr_valid = 1'b1;
    assign o_arr_wr_dirty = req_we_q;
    assign o_arr_wr_tag   = req_tag_q;
    assign o_arr_wr_line  = merged_line;

    assign o_mem_rd      = mem_rd_q;
    assign o_mem_wr      = mem_wr_q;
    assign o_mem_addr    = (state_q == WBACK) ? make_line_addr(victim_tag_q, req_index_q)
                                              : make_line_addr(req_tag_q, req_index_q);
    assign o_mem_wr_line = victim_line_q;

    assign o_busy  = (state_q != IDLE);
    assign o_done  = (state_q == RESP);
    assign o_rdata = rdata_q;

endmodule

// File: dcache_array.sv
// valid and dirty bits are bypassed from a same-cycle write to the read index; line data is not
`timescale 1ns/100ps

module dcache_array (
    input  logic                    clk,
    input  logic                    i_rst_n,

    // write port, takes effect at the clock edge
    input  logic                    i_wr_en,
    input  dcache_addr_pkg::index_t i_wr_index,
    input  logic                    i_wr_valid,
    input  logic                    i_wr_dirty,
    input  dcache_addr_pkg::tag_t   i_wr_tag,
    input  dcache_mem_pkg::line_t   i_wr_line,

    // read port, results appear one cycle after i_rd_en
    input  logic                    i_rd_en,
    input  dcache_addr_pkg::index_t i_rd_index,
    output logic                    o_rd_valid,
    output logic                    o_rd_dirty,
    output dcache_addr_pkg::tag_t   o_rd_tag,
    output dcache_mem_pkg::line_t   o_rd_line
);

    import dcache_addr_pkg::*;
    import dcache_mem_pkg::*;

    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;
    logic             wr_same_index;
    logic             rd_valid_d;
    logic             rd_dirty_d;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_wr_en) begin
            valid_q[i_wr_index] <= i_wr_valid;
            dirty_q[i_wr_index] <= i_wr_dirty;
        end
    end

    // a write landing on the index being read wins over the stored state
    assign wr_same_index = i_wr_en && (i_wr_index == i_rd_index);
    assign rd_valid_d    = wr_same_index ? i_wr_valid : valid_q[i_rd_index];
    assign rd_dirty_d    = wr_same_index ? i_wr_dirty : dirty_q[i_rd_index];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rd_valid <= 1'b0;
            o_rd_dirty <= 1'b0;
        end else if (i_rd_en) begin
            o_rd_valid <= rd_valid_d;
            o_rd_dirty <= rd_dirty_d;
        end
    end

    dcache_ram_sdp #(
        .T     (tag_t),
        .DEPTH (LINES)
    ) tag_ram (
        .clk       (clk),
        .i_rd_en   (i_rd_en),
        .i_rd_addr (i_rd_index),
        .o_rd_data (o_rd_tag),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_index),
        .i_wr_data (i_wr_tag)
    );

    dcache_ram_sdp #(
        .T     (line_t),
        .DEPTH (LINES)
    ) data_ram (
        .clk       (clk),
        .i_rd_en   (i_rd_en),
        .i_rd_addr (i_rd_index),
        .o_rd_data (o_rd_line),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_index),
        .i_wr_data (i_wr_line)
    );

endmodule

// File: dcache_ram_sdp.sv
// read-first simple dual-port RAM with one cycle read latency; contents are undefined after reset
`timescale 1ns/100ps

module dcache_ram_sdp #(
    parameter type T      = logic [7:0],
    parameter int  DEPTH  = 16,
    parameter int  ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,

    input  logic              i_rd_en,
    input  logic [ADDR_W-1:0] i_rd_addr,
    output T                  o_rd_data,

    input  logic              i_wr_en,
    input  logic [ADDR_W-1:0] i_wr_addr,
    input  T                  i_wr_data
);

    T mem [DEPTH];
    T rd_data_q;

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // the output keeps its last value while no read is enabled
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            rd_data_q <= mem[i_rd_addr];
        end
    end

    assign o_rd_data = rd_data_q;

endmodule

// File: dcache_mem_pkg.sv
// payload and controller state types; a line is packed with word 0 in the low bits
package dcache_mem_pkg;

    `include "dcache_cfg.svh"

    localparam int WORD_W     = `DCACHE_WORD_W;
    localparam int LINE_WORDS = (`DCACHE_LINE_BYTES * 8) / WORD_W;
    localparam int LINE_W     = LINE_WORDS * WORD_W;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;

    // one request in flight, so the controller walks these states in order
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WBACK,
        FILL,
        RESP
    } ctrl_state_t;

endpackage

// File: dcache_addr_pkg.sv
// address split for a direct-mapped cache; the byte offset bits of an address are ignored
package dcache_addr_pkg;

    `include "dcache_cfg.svh"

    localparam int ADDR_W     = `DCACHE_ADDR_W;
    localparam int BYTE_OFF_W = $clog2(`DCACHE_WORD_W / 8);
    localparam int WOFF_W     = $clog2(`DCACHE_LINE_BYTES) - BYTE_OFF_W;
    localparam int LINES      = `DCACHE_SIZE_BYTES / `DCACHE_LINE_BYTES;
    localparam int INDEX_W    = $clog2(LINES);
    localparam int TAG_W      = ADDR_W - INDEX_W - WOFF_W - BYTE_OFF_W;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WOFF_W-1:0]  woff_t;

    function automatic tag_t get_tag(addr_t addr);
        return addr[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t get_index(addr_t addr);
        return addr[BYTE_OFF_W + WOFF_W +: INDEX_W];
    endfunction

    function automatic woff_t get_woff(addr_t addr);
        return addr[BYTE_OFF_W +: WOFF_W];
    endfunction

    // rebuilds the line-aligned byte address of a line
    function automatic addr_t make_line_addr(tag_t tag, index_t index);
        return {tag, index, {(WOFF_W + BYTE_OFF_W){1'b0}}};
    endfunction

endpackage

// File: dcache_cfg.svh
// all sizes are powers of two; the line holds a whole number of words and the cache whole lines
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// byte address width seen by the CPU and the memory
`define DCACHE_ADDR_W 16

// CPU word width, accesses are always word aligned
`define DCACHE_WORD_W 32

// bytes per cache line
`define DCACHE_LINE_BYTES 16

// total capacity in bytes, giving 16 lines of 4 words
`define DCACHE_SIZE_BYTES 256

`endif
